// ==== bench/fmDemodInput.txt ====
// columns: I, Q, expected FM video, all 18-bit two's complement hex
// first word is the number of sample lines that follow
10
10000 00000 00000
00000 10000 08000
30000 00000 08000
00000 30000 08000
10000 00000 08000
0c000 0c000 06000
00000 10000 06000
34000 0c000 06000
00000 10000 3a000
0c000 0c000 3a000
10000 00000 3a000
00000 30000 38000
38000 3c000 3c000
04000 34000 03800
08000 08000 04000
3c000 04000 02000

// ==== all.f ====
logic/demodPkg.sv
logic/sampleLink.sv
logic/fmDiscriminator.sv
logic/sampleFifo.sv
logic/freqMonitor.sv
logic/fmDemodTop.sv
bench/fmDemodTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fmDemodTb -f all.f -o fmDemodSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fmDemodSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
exit 1

// ==== bench/fmDemodTb.sv ====
// Testbench for the FM video and false-lock monitor path.
// Replays I/Q lines from bench/fmDemodInput.txt under several register setups
// and checks every dacSync against a model of the discriminator and averages.

`timescale 1ns/1ps

module fmDemodTb;

    localparam int maxLines    = 32;
    localparam int toneLen     = 12;
    localparam int burstLen    = 40;
    localparam int resetCycles = 3;
    localparam int toneAmp     = 100000;

    logic clk;
    logic arstN;
    logic sampleEn;
    logic carrierLock;
    logic cfgWr;
    logic [31:0] cfgData;
    logic sampleReady;
    logic dacSync;
    logic highFreqOffset;
    demodPkg::sample_t  iIn;
    demodPkg::sample_t  qIn;
    demodPkg::sample_t  dacData;
    demodPkg::cfgAddr_t cfgAddr;

    logic [17:0] stim [0:3*maxLines];
    int numLines;
    int limitCycles;
    int errorCount;
    int checkCount;
    int acceptCount;
    int syncCount;
    int stallCount;
    int stallBefore;
    int flagHighCount;
    int flagBefore;

    // model state and register shadow
    demodPkg::sample_t prevI;
    demodPkg::sample_t prevQ;
    demodPkg::sample_t avgF;
    demodPkg::sample_t avgA;
    demodPkg::alpha_t  alphaCfg;
    logic [15:0]       thresholdCfg;
    demodPkg::dacSel_t selCfg;
    logic              swapCfg;
    demodPkg::sample_t expData [$];
    logic              expFlag [$];
    demodPkg::sample_t wantData;
    logic              wantFlag;

    fmDemodTop #(.fifoDepth(8)) DUT (
        .clk(clk), .arstN(arstN), .sampleEn(sampleEn), .iIn(iIn), .qIn(qIn),
        .carrierLock(carrierLock), .cfgWr(cfgWr), .cfgAddr(cfgAddr), .cfgData(cfgData),
        .sampleReady(sampleReady), .dacData(dacData), .dacSync(dacSync),
        .highFreqOffset(highFreqOffset)
    );

    always #20 clk = ~clk;

    // bits 34..17 of the cross product difference
    function automatic demodPkg::sample_t crossVideo(demodPkg::sample_t pI, demodPkg::sample_t pQ,
                                                     demodPkg::sample_t cI, demodPkg::sample_t cQ);
        longint diff;
        diff = longint'(pI) * longint'(cQ) - longint'(pQ) * longint'(cI);
        return diff[34:17];
    endfunction

    // exponential average with signed 18 bit a = alpha*4 and b = 2^17-1-a
    function automatic demodPkg::sample_t smooth(demodPkg::sample_t x, demodPkg::sample_t old,
                                                 demodPkg::alpha_t al);
        longint a;
        longint b;
        longint acc;
        a = longint'({al, 2'b00});
        if (a > 131071) a = a - 262144;
        b = 131071 - a;
        if (b > 131071) b = b - 262144;
        acc = longint'(x) * a + longint'(old) * b;
        return acc[34:17];
    endfunction

    task automatic predict(input demodPkg::sample_t i, input demodPkg::sample_t q,
                           input logic fromFile, input demodPkg::sample_t fileVideo);
        demodPkg::sample_t si;
        demodPkg::sample_t sq;
        demodPkg::sample_t video;
        demodPkg::sample_t mag;
        demodPkg::sample_t shown;
        longint freqAbs;
        logic flag;
        si = swapCfg ? q : i;
        sq = swapCfg ? i : q;
        video = fromFile ? fileVideo : crossVideo(prevI, prevQ, si, sq);
        prevI = si;
        prevQ = sq;
        mag = (video < 0) ? -video : video;
        avgF = smooth(video, avgF, alphaCfg);
        avgA = smooth(mag, avgA, alphaCfg);
        freqAbs = (avgF < 0) ? -longint'(avgF) : longint'(avgF);
        if (avgA > demodPkg::absLimit) flag = 1'b1;
        else if (freqAbs > longint'(thresholdCfg)) flag = !carrierLock;
        else flag = 1'b0;
        case (selCfg)
            demodPkg::dacQ:          shown = sq;
            demodPkg::dacFmVideo:    shown = video;
            demodPkg::dacAvgFreq:    shown = avgF;
            demodPkg::dacAvgAbsFreq: shown = avgA;
            default:                 shown = si;
        endcase
        expData.push_back(shown);
        expFlag.push_back(flag);
        acceptCount++;
    endtask

    // holds the sample until sampleReady lets it in
    task automatic offer(input demodPkg::sample_t i, input demodPkg::sample_t q,
                         input logic fromFile, input demodPkg::sample_t fileVideo);
        @(posedge clk);
        sampleEn <= 1'b1;
        iIn      <= i;
        qIn      <= q;
        @(negedge clk);
        while (!sampleReady) begin
            stallCount++;
            @(negedge clk);
        end
        predict(i, q, fromFile, fileVideo);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            sampleEn <= 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (expData.size() != 0) @(negedge clk);
    endtask

    task automatic writeReg(input demodPkg::cfgAddr_t addr, input logic [31:0] data);
        @(posedge clk);
        cfgWr   <= 1'b1;
        cfgAddr <= addr;
        cfgData <= data;
        @(posedge clk);
        cfgWr <= 1'b0;
    endtask

    task automatic setLoop(input demodPkg::alpha_t al, input logic [15:0] thr);
        alphaCfg     = al;
        thresholdCfg = thr;
        writeReg(demodPkg::addrLoop, {al, thr});
    endtask

    task automatic setOutput(input demodPkg::dacSel_t sel, input logic swap);
        selCfg  = sel;
        swapCfg = swap;
        writeReg(demodPkg::addrOutput, {27'd0, sel, swap});
    endtask

    // stepLock sends one sample at a time and flips carrierLock before each
    task automatic playFile(input int gapMax, input logic fromFile, input logic stepLock);
        int n;
        for (n = 0; n < numLines; n++) begin
            if (stepLock) begin
                @(posedge clk);
                carrierLock <= !carrierLock;
            end
            offer(stim[1+3*n], stim[2+3*n], fromFile, stim[3+3*n]);
            if (stepLock) drain();
            else idle(int'($urandom() % (gapMax + 1)));
        end
        drain();
    endtask

    // quarter turn per sample gives a constant large frequency
    task automatic playTone();
        int n;
        demodPkg::sample_t amp;
        amp = demodPkg::sample_t'(toneAmp);
        for (n = 0; n < toneLen; n++) begin
            case (n % 4)
                0:       offer(amp, '0, 1'b0, '0);
                1:       offer('0, amp, 1'b0, '0);
                2:       offer(-amp, '0, 1'b0, '0);
                default: offer('0, -amp, 1'b0, '0);
            endcase
        end
        drain();
    endtask

    task automatic printSummary();
        $display("Summary: %0d checks, %0d errors, %0d accepted, %0d dacSync, %0d stalls",
                 checkCount, errorCount, acceptCount, syncCount, stallCount);
    endtask

    always @(negedge clk) begin
        if (arstN && dacSync) begin
            syncCount++;
            if (highFreqOffset) flagHighCount++;
            assert (expData.size() != 0) else begin
                errorCount++;
                $display("Unexpected dacSync pulse at %0t with no sample outstanding", $time);
            end
            if (expData.size() != 0) begin
                wantData = expData.pop_front();
                wantFlag = expFlag.pop_front();
                checkCount++;
                assert (dacData == wantData) else begin
                    errorCount++;
                    $display("Error at %0t: dacData expected %0d got %0d",
                             $time, wantData, dacData);
                end
                assert (highFreqOffset == wantFlag) else begin
                    errorCount++;
                    $display("Error at %0t: highFreqOffset expected %0b got %0b",
                             $time, wantFlag, highFreqOffset);
                end
            end
        end
    end

    initial begin
        wait (limitCycles != 0);
        repeat (limitCycles) @(posedge clk);
        $display("Timeout after %0d cycles with %0d samples still outstanding",
                 limitCycles, expData.size());
        printSummary();
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(28));
        clk = 1'b0;
        arstN = 1'b0;
        sampleEn = 1'b0;
        iIn = '0;
        qIn = '0;
        carrierLock = 1'b1;
        cfgWr = 1'b0;
        cfgAddr = '0;
        cfgData = '0;
        prevI = '0;
        prevQ = '0;
        avgF = '0;
        avgA = '0;
        $readmemh("bench/fmDemodInput.txt", stim);
        numLines = int'(stim[0]);
        limitCycles = resetCycles + 200 * (6 * numLines + toneLen + burstLen);
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        assert (sampleReady && !dacSync && !highFreqOffset) else begin
            errorCount++;
            $display("Outputs not in their reset state after reset release");
        end

        setLoop(16'h1000, 16'h7fff);
        setOutput(demodPkg::dacFmVideo, 1'b0);
        playFile(3, 1'b1, 1'b0);
        setOutput(demodPkg::dacI, 1'b1);
        playFile(3, 1'b0, 1'b0);
        setOutput(demodPkg::dacQ, 1'b1);
        playFile(3, 1'b0, 1'b0);

        setLoop(16'h2000, 16'h7fff);
        setOutput(demodPkg::dacAvgFreq, 1'b0);
        playFile(2, 1'b0, 1'b0);
        setOutput(demodPkg::dacAvgAbsFreq, 1'b0);
        playFile(2, 1'b0, 1'b0);

        // low threshold so carrierLock decides the flag
        setLoop(16'h4000, 16'h0100);
        playFile(0, 1'b0, 1'b1);
        @(posedge clk);
        carrierLock <= 1'b1;
        flagBefore = flagHighCount;
        playTone();
        assert (flagHighCount > flagBefore) else begin
            errorCount++;
            $display("The constant offset tone never raised highFreqOffset");
        end

        // back to back burst against the credit limit
        setOutput(demodPkg::dacFmVideo, 1'b0);
        stallBefore = stallCount;
        repeat (burstLen) begin
            offer(demodPkg::sample_t'($urandom()), demodPkg::sample_t'($urandom()), 1'b0, '0);
        end
        drain();
        assert (stallCount > stallBefore) else begin
            errorCount++;
            $display("The burst never saw sampleReady drop");
        end
        assert (syncCount == acceptCount) else begin
            errorCount++;
            $display("Count of dacSync pulses differs from the accepted samples");
        end

        printSummary();
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== logic/fmDemodTop.sv ====
// Top level of the FM video and false-lock monitor path.
// Holds the write-only register block and joins discriminator, buffer
// and monitor through two sample links.

`timescale 1ns/1ps

module fmDemodTop #(
    parameter int fifoDepth = 8
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic               sampleEn,
    input  demodPkg::sample_t  iIn,
    input  demodPkg::sample_t  qIn,
    input  logic               carrierLock,
    input  logic               cfgWr,
    input  demodPkg::cfgAddr_t cfgAddr,
    input  logic [31:0]        cfgData,
    output logic               sampleReady,
    output demodPkg::sample_t  dacData,
    output logic               dacSync,
    output logic               highFreqOffset
);

    demodPkg::cfgWord_u cfgWord;
    demodPkg::alpha_t   falseLockAlpha;
    logic [15:0]        falseLockThreshold;
    demodPkg::dacSel_t  dacSelect;
    logic               iqSwap;

    assign cfgWord = cfgData;

    // loop and output registers
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            falseLockAlpha     <= '0;
            falseLockThreshold <= '0;
            dacSelect          <= '0;
            iqSwap             <= 1'b0;
        end else if (cfgWr) begin
            case (cfgAddr)
                demodPkg::addrLoop: begin
                    falseLockAlpha     <= cfgWord.loopView.falseLockAlpha;
                    falseLockThreshold <= cfgWord.loopView.falseLockThreshold;
                end
                demodPkg::addrOutput: begin
                    dacSelect <= cfgWord.outputView.dacSelect;
                    iqSwap    <= cfgWord.outputView.iqSwap;
                end
                default: begin
                    // unused addresses are ignored
                end
            endcase
        end
    end

    sampleLink toBuffer ();
    sampleLink toMonitor ();

    fmDiscriminator #(
        .fifoDepth (fifoDepth)
    ) discriminator (
        .clk         (clk),
        .arstN       (arstN),
        .sampleEn    (sampleEn),
        .iIn         (iIn),
        .qIn         (qIn),
        .iqSwap      (iqSwap),
        .sampleReady (sampleReady),
        .link        (toBuffer)
    );

    sampleFifo #(
        .fifoDepth (fifoDepth)
    ) buffer (
        .clk     (clk),
        .arstN   (arstN),
        .inLink  (toBuffer),
        .outLink (toMonitor)
    );

    freqMonitor monitor (
        .clk            (clk),
        .arstN          (arstN),
        .link           (toMonitor),
        .alpha          (falseLockAlpha),
        .threshold      (falseLockThreshold),
        .dacSelect      (dacSelect),
        .carrierLock    (carrierLock),
        .dacData        (dacData),
        .dacSync        (dacSync),
        .highFreqOffset (highFreqOffset)
    );

endmodule

// ==== logic/freqMonitor.sv ====
// False-lock monitor and DAC source select.
// Takes one sample every four cycles and shares two multipliers between
// the frequency and absolute frequency averages.

`timescale 1ns/1ps

module freqMonitor (
    input  logic              clk,
    input  logic              arstN,
    sampleLink.receiver       link,
    input  demodPkg::alpha_t  alpha,
    input  logic [15:0]       threshold,
    input  demodPkg::dacSel_t dacSelect,
    input  logic              carrierLock,
    output demodPkg::sample_t dacData,
    output logic              dacSync,
    output logic              highFreqOffset
);

    logic [1:0]         step;
    logic               take;
    demodPkg::sample_t  videoReg;
    demodPkg::sample_t  iReg;
    demodPkg::sample_t  qReg;
    demodPkg::sample_t  absVideo;
    demodPkg::sample_t  coefA;
    demodPkg::sample_t  coefB;
    demodPkg::sample_t  mulOpA;
    demodPkg::sample_t  mulOpB;
    demodPkg::sample_t  avgFreq;
    demodPkg::sample_t  avgAbsFreq;
    demodPkg::sample_t  newFreq;
    demodPkg::sample_t  newAbs;
    demodPkg::product_t prodA;
    demodPkg::product_t prodB;
    demodPkg::product_t prodSum;
    logic [17:0]        freqMag;

    // step 0 idle, 1 freq products, 2 abs products, 3 commit
    assign take              = (step == 2'd0) & link.valid;
    assign link.creditReturn = take;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            step <= 2'd0;
        end else if (step == 2'd0) begin
            if (link.valid) begin
                step <= 2'd1;
            end
        end else begin
            step <= step + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            videoReg <= link.data;
            iReg     <= link.iData;
            qReg     <= link.qData;
        end
    end

    // a = alpha << 2, b = 2^17 - 1 - a
    assign coefA = {alpha, 2'b00};
    assign coefB = 18'h1ffff - coefA;

    assign absVideo = videoReg[17] ? -videoReg : videoReg;
    assign mulOpA   = (step == 2'd1) ? videoReg : absVideo;
    assign mulOpB   = (step == 2'd1) ? avgFreq : avgAbsFreq;

    // shared multiplier pair
    always_ff @(posedge clk) begin
        prodA <= mulOpA * coefA;
        prodB <= mulOpB * coefB;
        if (step == 2'd2) begin
            newFreq <= prodSum[34:17];
        end
    end

    assign prodSum = prodA + prodB;
    assign newAbs  = prodSum[34:17];
    assign freqMag = newFreq[17] ? 18'(-newFreq) : 18'(newFreq);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            avgFreq        <= '0;
            avgAbsFreq     <= '0;
            highFreqOffset <= 1'b0;
            dacData        <= '0;
            dacSync        <= 1'b0;
        end else begin
            dacSync <= step == 2'd3;
            if (step == 2'd3) begin
                avgFreq    <= newFreq;
                avgAbsFreq <= newAbs;
                if (newAbs > demodPkg::absLimit) begin
                    highFreqOffset <= 1'b1;
                end else if (freqMag > {2'b00, threshold}) begin
                    // raised only while the carrier loop reports no lock
                    highFreqOffset <= !carrierLock;
                end else begin
                    highFreqOffset <= 1'b0;
                end
                case (dacSelect)
                    demodPkg::dacI:          dacData <= iReg;
                    demodPkg::dacQ:          dacData <= qReg;
                    demodPkg::dacFmVideo:    dacData <= videoReg;
                    demodPkg::dacAvgFreq:    dacData <= newFreq;
                    demodPkg::dacAvgAbsFreq: dacData <= newAbs;
                    default:                 dacData <= iReg;
                endcase
            end
        end
    end

endmodule

// ==== logic/sampleFifo.sv ====
// Small circular buffer between the discriminator and the monitor.
// Head is offered whenever not empty; each pop sends a credit upstream.

`timescale 1ns/1ps

module sampleFifo #(
    parameter int fifoDepth = 8
) (
    input  logic        clk,
    input  logic        arstN,
    sampleLink.receiver inLink,
    sampleLink.sender   outLink
);

    localparam int ptrWidth   = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
    localparam int countWidth = $clog2(fifoDepth + 1);

    demodPkg::sample_t     videoMem [fifoDepth];
    demodPkg::sample_t     iMem     [fifoDepth];
    demodPkg::sample_t     qMem     [fifoDepth];
    logic [ptrWidth-1:0]   wrPtr;
    logic [ptrWidth-1:0]   rdPtr;
    logic [countWidth-1:0] count;
    logic                  push;
    logic                  pop;
    logic                  creditPulse;

    // producer credits guarantee room for every push
    assign push = inLink.valid;
    assign pop  = outLink.creditReturn & (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            videoMem[wrPtr] <= inLink.data;
            iMem[wrPtr]     <= inLink.iData;
            qMem[wrPtr]     <= inLink.qData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            count       <= '0;
            creditPulse <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == ptrWidth'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrWidth'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count       <= count + countWidth'(push) - countWidth'(pop);
            creditPulse <= pop;
        end
    end

    assign inLink.creditReturn = creditPulse;

    assign outLink.valid = count != '0;
    assign outLink.data  = videoMem[rdPtr];
    assign outLink.iData = iMem[rdPtr];
    assign outLink.qData = qMem[rdPtr];

endmodule

// ==== logic/fmDiscriminator.sv ====
// Cross-product FM discriminator with optional I/Q swap.
// Sends each video sample with its swapped I/Q two cycles after acceptance,
// and only while it holds enough credits for the downstream buffer.

`timescale 1ns/1ps

module fmDiscriminator #(
    parameter int fifoDepth = 8
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              sampleEn,
    input  demodPkg::sample_t iIn,
    input  demodPkg::sample_t qIn,
    input  logic              iqSwap,
    output logic              sampleReady,
    sampleLink.sender         link
);

    localparam int creditWidth = $clog2(fifoDepth + 1);

    demodPkg::sample_t  iSwapped;
    demodPkg::sample_t  qSwapped;
    demodPkg::sample_t  iPrev;
    demodPkg::sample_t  qPrev;
    demodPkg::sample_t  iStage;
    demodPkg::sample_t  qStage;
    demodPkg::sample_t  iOut;
    demodPkg::sample_t  qOut;
    demodPkg::sample_t  videoOut;
    demodPkg::product_t prodIq;
    demodPkg::product_t prodQi;
    demodPkg::product_t diff;
    logic               accept;
    logic               stageValid;
    logic               outValid;
    logic [creditWidth-1:0] credits;
    logic [creditWidth-1:0] inFlight;

    assign iSwapped = iqSwap ? qIn : iIn;
    assign qSwapped = iqSwap ? iIn : qIn;

    // samples already accepted but not yet sent
    assign inFlight    = creditWidth'(stageValid) + creditWidth'(outValid);
    assign sampleReady = credits > inFlight;
    assign accept      = sampleEn & sampleReady;

    // previous swapped sample and pipeline valid flags
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            iPrev      <= '0;
            qPrev      <= '0;
            stageValid <= 1'b0;
            outValid   <= 1'b0;
        end else begin
            if (accept) begin
                iPrev <= iSwapped;
                qPrev <= qSwapped;
            end
            stageValid <= accept;
            outValid   <= stageValid;
        end
    end

    // stage 1 products, stage 2 difference
    always_ff @(posedge clk) begin
        if (accept) begin
            prodIq <= iPrev * qSwapped;
            prodQi <= qPrev * iSwapped;
            iStage <= iSwapped;
            qStage <= qSwapped;
        end
        if (stageValid) begin
            videoOut <= diff[34:17];
            iOut     <= iStage;
            qOut     <= qStage;
        end
    end

    assign diff = prodIq - prodQi;

    // one credit spent per send, one back per return pulse
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            credits <= creditWidth'(fifoDepth);
        end else begin
            credits <= credits - creditWidth'(outValid) + creditWidth'(link.creditReturn);
        end
    end

    assign link.valid = outValid;
    assign link.data  = videoOut;
    assign link.iData = iOut;
    assign link.qData = qOut;

endmodule

// ==== logic/sampleLink.sv ====
// Sample link between pipeline blocks.
// Carries the FM video sample with its I/Q pair forward and credits back.

`timescale 1ns/1ps

interface sampleLink;

    logic               valid;
    demodPkg::sample_t  data;
    demodPkg::sample_t  iData;
    demodPkg::sample_t  qData;
    // one pulse per freed slot downstream
    logic               creditReturn;

    modport sender (
        output valid,
        output data,
        output iData,
        output qData,
        input  creditReturn
    );

    modport receiver (
        input  valid,
        input  data,
        input  iData,
        input  qData,
        output creditReturn
    );

endinterface

// ==== logic/demodPkg.sv ====
// Shared types and constants for the FM video and false-lock monitor path.
// Reach the definitions with demodPkg::name from the modules.

package demodPkg;

    localparam int sampleWidth = 18;

    typedef logic signed [sampleWidth-1:0]   sample_t;
    typedef logic signed [2*sampleWidth-1:0] product_t;
    typedef logic [15:0]                     alpha_t;
    typedef logic [3:0]                      dacSel_t;
    typedef logic [1:0]                      cfgAddr_t;

    // monitor DAC sources where unknown codes fall back to I
    localparam dacSel_t dacI          = 4'd0;
    localparam dacSel_t dacQ          = 4'd1;
    localparam dacSel_t dacFmVideo    = 4'd2;
    localparam dacSel_t dacAvgFreq    = 4'd3;
    localparam dacSel_t dacAvgAbsFreq = 4'd4;

    // register block addresses
    localparam cfgAddr_t addrLoop   = 2'd0;
    localparam cfgAddr_t addrOutput = 2'd1;

    // averaged |freq| above this always flags a high offset
    localparam sample_t absLimit = 18'sh10000;

    typedef struct packed {
        alpha_t      falseLockAlpha;
        logic [15:0] falseLockThreshold;
    } cfgLoop_t;

    typedef struct packed {
        logic [26:0] spare;
        dacSel_t     dacSelect;
        logic        iqSwap;
    } cfgOutput_t;

    // one write word whose meaning depends on the address
    typedef union packed {
        cfgLoop_t   loopView;
        cfgOutput_t outputView;
    } cfgWord_u;

endpackage
